//--- list.f
+incdir+.
lcd_pkg.sv
lcd_timing.sv
lcd_cmd_store.sv
lcd_display.sv
lcd_top.sv
tb_lcd_top.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module tb_lcd_top -Mdir obj_dir
	./obj_dir/Vtb_lcd_top | tee /dev/stderr | grep -F -q '*** PASSED ***'

clean:
	rm -rf obj_dir

//--- tb_lcd_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "lcd_settings.svh"

module tb_lcd_top;

	localparam int H_DISP = `LCD_H_DISP;
	localparam int V_DISP = `LCD_V_DISP;
	localparam int H_SYNC_ON = `LCD_H_DISP + `LCD_H_FRONT;
	localparam int H_SYNC = `LCD_H_SYNC;
	localparam int H_TOTAL = `LCD_H_TOTAL;
	localparam int SLOTS = `LCD_SLOTS;
	// a frame is about 3000 cycles
	localparam int WAIT_LIMIT = 8000;

	logic clk;
	logic rst_n;
	logic cmd_strobe;
	logic [31:0] cmd_data;
	logic lcd_de;
	logic lcd_hsync;
	logic lcd_vsync;
	logic [23:0] lcd_data;

	// reference copy of the drawing records and pattern
	int m_valid [SLOTS];
	int m_x0 [SLOTS];
	int m_y0 [SLOTS];
	int m_x1 [SLOTS];
	int m_y1 [SLOTS];
	logic [23:0] m_color [SLOTS];
	lcd_pkg::pattern_t m_pattern;
	int m_ptr;

	// scan position seen from the panel side
	int mx;
	int my;
	int hx;
	logic de_q;
	logic vs_q;
	logic [23:0] exp_rgb;
	logic exp_hs;
	int errors;
	int pixels;
	int frames;
	logic [31:0] rng_state;

	lcd_top u_lcd_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd_strobe(cmd_strobe),
		.cmd_data  (cmd_data),
		.lcd_de    (lcd_de),
		.lcd_hsync (lcd_hsync),
		.lcd_vsync (lcd_vsync),
		.lcd_data  (lcd_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] next_random();
		logic [31:0] s;
		s = rng_state;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		rng_state = s;
		return s;
	endfunction

	function automatic logic [23:0] band_color(input int band);
		case (band)
			0: return `LCD_RED;
			1: return `LCD_GREEN;
			2: return `LCD_BLUE;
			3: return `LCD_WHITE;
			4: return `LCD_BLACK;
			5: return `LCD_YELLOW;
			6: return `LCD_CYAN;
			default: return `LCD_ROYAL;
		endcase
	endfunction

	function automatic logic [23:0] expected_pixel(input int x, input int y);
		logic [23:0] c;
		case (m_pattern)
			lcd_pkg::pat_hbars: c = band_color(y / (V_DISP / 8));
			lcd_pkg::pat_vbars: c = band_color(x / (H_DISP / 8));
			lcd_pkg::pat_product: c = 24'(x * y);
			default: c = (y < V_DISP / 2) ? {3{8'(y)}} : {3{8'(x)}};
		endcase
		// highest slot index wins, so search downwards
		for (int k = SLOTS - 1; k >= 0; k--)
		begin
			if (m_valid[k] != 0 && x >= m_x0[k] && x <= m_x1[k] && y >= m_y0[k]
				&& y <= m_y1[k])
				return m_color[k];
		end
		return c;
	endfunction

	// ------------------------------------------------------------------------
	// panel side checker
	// ------------------------------------------------------------------------
	always @(negedge clk)
	begin
		if (rst_n)
		begin
			if (lcd_de)
			begin
				exp_rgb = expected_pixel(mx, my);
				assert (lcd_data === exp_rgb)
				else
				begin
					errors++;
					$display("[ERROR] %0t lcd_data got %h expected %h (x=%0d y=%0d)",
						$time, lcd_data, exp_rgb, mx, my);
				end
				mx++;
				pixels++;
			end
			else
			begin
				assert (lcd_data === 24'h0)
				else
				begin
					errors++;
					$display("[ERROR] %0t lcd_data got %h expected %h with lcd_de low",
						$time, lcd_data, 24'h0);
				end
				if (de_q)
				begin
					assert (mx == H_DISP)
					else
					begin
						errors++;
						$display("%0t line had %0d enabled pixels instead of %0d",
							$time, mx, H_DISP);
					end
					mx = 0;
					my++;
				end
			end
			// horizontal position, known from the first enable rise on
			if (lcd_de && !de_q)
				hx = 0;
			else if (hx >= 0)
				hx = (hx + 1) % H_TOTAL;
			if (hx >= 0)
			begin
				exp_hs = !((hx >= H_SYNC_ON) && (hx < H_SYNC_ON + H_SYNC));
				assert (lcd_hsync === exp_hs)
				else
				begin
					errors++;
					$display("[ERROR] %0t lcd_hsync got %b expected %b (x=%0d)",
						$time, lcd_hsync, exp_hs, hx);
				end
			end
			if (vs_q && !lcd_vsync)
			begin
				assert (my == V_DISP)
				else
				begin
					errors++;
					$display("%0t frame had %0d visible lines instead of %0d",
						$time, my, V_DISP);
				end
				my = 0;
				frames++;
			end
			de_q = lcd_de;
			vs_q = lcd_vsync;
		end
	end

	// ------------------------------------------------------------------------
	// waits and command tasks
	// ------------------------------------------------------------------------
	task automatic wait_vsync_level(input logic level);
		int n;
		n = 0;
		while (lcd_vsync !== level && n < WAIT_LIMIT)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		if (n >= WAIT_LIMIT)
		begin
			errors++;
			$display("timeout: lcd_vsync did not reach %b within %0d cycles", level, n);
		end
	endtask

	// next vsync fall, i.e. the previous frame has been fully checked
	task automatic wait_vsync_fall();
		wait_vsync_level(1'b1);
		wait_vsync_level(1'b0);
	endtask

	task automatic send_word(input logic [31:0] w);
		@(posedge clk);
		#1;
		cmd_strobe = 1'b1;
		cmd_data = w;
		@(posedge clk);
		#1;
		cmd_strobe = 1'b0;
		cmd_data = '0;
	endtask

	task automatic store_record(input int xa, input int ya, input int xb, input int yb,
		input logic [23:0] c);
		m_valid[m_ptr] = 1;
		m_x0[m_ptr] = (xa < xb) ? xa : xb;
		m_x1[m_ptr] = (xa < xb) ? xb : xa;
		m_y0[m_ptr] = (ya < yb) ? ya : yb;
		m_y1[m_ptr] = (ya < yb) ? yb : ya;
		m_color[m_ptr] = c;
		m_ptr = (m_ptr + 1) % SLOTS;
	endtask

	task automatic set_pattern(input lcd_pkg::pattern_t p);
		send_word({8'hFF, 8'h00, 8'h03, 6'd0, 2'(p)});
		m_pattern = p;
	endtask

	task automatic clear_slots();
		send_word(32'hFF00_0400);
		for (int k = 0; k < SLOTS; k++)
			m_valid[k] = 0;
		m_ptr = 0;
	endtask

	// upper colour byte is junk that the store must drop
	task automatic draw_pixel(input int x, input int y, input logic [23:0] c);
		send_word(32'hFF00_0000);
		send_word({16'(x), 16'(y)});
		send_word({8'hA5, c});
		store_record(x, y, x, y, c);
	endtask

	task automatic draw_rect(input int xa, input int ya, input int xb, input int yb,
		input logic [23:0] c);
		send_word(32'hFF00_0200);
		send_word({16'(xa), 16'(ya)});
		send_word({16'(xb), 16'(yb)});
		send_word({8'h5A, c});
		store_record(xa, ya, xb, yb, c);
	endtask

	// rectangle with its corners given bottom-right first
	task automatic draw_random_swapped_rect();
		int xa;
		int xb;
		int ya;
		int yb;
		xa = next_random() % H_DISP;
		xb = next_random() % H_DISP;
		ya = next_random() % V_DISP;
		yb = next_random() % V_DISP;
		draw_rect((xa > xb) ? xa : xb, (ya > yb) ? ya : yb, (xa > xb) ? xb : xa,
			(ya > yb) ? yb : ya, 24'(next_random()));
	endtask

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------
	initial
	begin
		rst_n = 1'b0;
		cmd_strobe = 1'b0;
		cmd_data = '0;
		rng_state = 32'h7b2e1af7;
		m_pattern = lcd_pkg::pat_hbars;
		m_ptr = 0;
		for (int k = 0; k < SLOTS; k++)
			m_valid[k] = 0;
		mx = 0;
		my = 0;
		hx = -1;
		de_q = 1'b0;
		vs_q = 1'b1;
		errors = 0;
		pixels = 0;
		frames = 0;
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// bare horizontal bars straight out of reset
		wait_vsync_fall();

		set_pattern(lcd_pkg::pat_vbars);
		wait_vsync_fall();
		set_pattern(lcd_pkg::pat_product);
		wait_vsync_fall();
		wait_vsync_fall();
		set_pattern(lcd_pkg::pat_gray);
		wait_vsync_fall();
		set_pattern(lcd_pkg::pat_hbars);
		wait_vsync_fall();

		// single pixels and swapped-corner rectangles
		set_pattern(lcd_pkg::pat_vbars);
		repeat (3)
		begin
			clear_slots();
			draw_random_swapped_rect();
			draw_pixel(next_random() % H_DISP, next_random() % V_DISP, 24'(next_random()));
			wait_vsync_fall();
		end

		// five records wrap over four slots, overlaps resolved by index
		clear_slots();
		repeat (SLOTS + 1)
			draw_random_swapped_rect();
		wait_vsync_fall();

		// bad marker and unknown opcode are dropped along with their payload words
		send_word(32'h7E00_0200);
		send_word(32'h0000_0000);
		send_word(32'h003F_001F);
		send_word(32'h00FF_00FF);
		send_word(32'hFF00_0100);
		send_word(32'h0000_0000);
		send_word(32'h00FF_00FF);
		wait_vsync_fall();
		clear_slots();
		wait_vsync_fall();

		// let the checker close the last frame
		@(negedge clk);
		#1;

		if (frames < 12)
		begin
			errors++;
			$display("only %0d frames were checked", frames);
		end
		$display("errors %0d, pixels checked %0d, frames %0d", errors, pixels, frames);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- lcd_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "lcd_settings.svh"

module lcd_top
(
	input wire clk,
	input wire rst_n,
	input wire cmd_strobe,
	input wire lcd_pkg::cmd_word_t cmd_data,
	output logic lcd_de,
	output logic lcd_hsync,
	output logic lcd_vsync,
	output lcd_pkg::rgb_t lcd_data
);

	// scan position
	wire lcd_pkg::coord_t pos_x;
	wire lcd_pkg::coord_t pos_y;
	wire pos_active;

	// drawing records and pattern select
	wire [`LCD_SLOTS-1:0] slot_valid;
	wire lcd_pkg::coord_t [`LCD_SLOTS-1:0] slot_x0;
	wire lcd_pkg::coord_t [`LCD_SLOTS-1:0] slot_y0;
	wire lcd_pkg::coord_t [`LCD_SLOTS-1:0] slot_x1;
	wire lcd_pkg::coord_t [`LCD_SLOTS-1:0] slot_y1;
	wire lcd_pkg::rgb_t [`LCD_SLOTS-1:0] slot_color;
	wire lcd_pkg::pattern_t pattern;

	lcd_timing u_timing (
		.clk        (clk),
		.rst_n      (rst_n),
		.pos_x      (pos_x),
		.pos_y      (pos_y),
		.pos_active (pos_active),
		.lcd_de     (lcd_de),
		.lcd_hsync  (lcd_hsync),
		.lcd_vsync  (lcd_vsync)
	);

	lcd_cmd_store u_cmd_store (
		.clk        (clk),
		.rst_n      (rst_n),
		.cmd_strobe (cmd_strobe),
		.cmd_data   (cmd_data),
		.slot_valid (slot_valid),
		.slot_x0    (slot_x0),
		.slot_y0    (slot_y0),
		.slot_x1    (slot_x1),
		.slot_y1    (slot_y1),
		.slot_color (slot_color),
		.pattern    (pattern)
	);

	lcd_display u_display (
		.clk        (clk),
		.rst_n      (rst_n),
		.pos_x      (pos_x),
		.pos_y      (pos_y),
		.pos_active (pos_active),
		.slot_valid (slot_valid),
		.slot_x0    (slot_x0),
		.slot_y0    (slot_y0),
		.slot_x1    (slot_x1),
		.slot_y1    (slot_y1),
		.slot_color (slot_color),
		.pattern    (pattern),
		.lcd_data   (lcd_data)
	);

endmodule

`default_nettype wire

//--- lcd_display.sv
`timescale 1ns/10ps
`default_nettype none

`include "lcd_settings.svh"

module lcd_display
(
	input wire clk,
	input wire rst_n,
	input wire lcd_pkg::coord_t pos_x,
	input wire lcd_pkg::coord_t pos_y,
	input wire pos_active,
	input wire [`LCD_SLOTS-1:0] slot_valid,
	input wire lcd_pkg::coord_t [`LCD_SLOTS-1:0] slot_x0,
	input wire lcd_pkg::coord_t [`LCD_SLOTS-1:0] slot_y0,
	input wire lcd_pkg::coord_t [`LCD_SLOTS-1:0] slot_x1,
	input wire lcd_pkg::coord_t [`LCD_SLOTS-1:0] slot_y1,
	input wire lcd_pkg::rgb_t [`LCD_SLOTS-1:0] slot_color,
	input wire lcd_pkg::pattern_t pattern,
	output lcd_pkg::rgb_t lcd_data
);

	// band sizes for the colour bar patterns
	localparam lcd_pkg::coord_t BAND_H = lcd_pkg::coord_t'(`LCD_V_DISP / 8);
	localparam lcd_pkg::coord_t BAND_W = lcd_pkg::coord_t'(`LCD_H_DISP / 8);
	localparam lcd_pkg::coord_t HALF_V = lcd_pkg::coord_t'(`LCD_V_DISP / 2);

	lcd_pkg::coord_t band_y;
	lcd_pkg::coord_t band_x;
	lcd_pkg::rgb_t product;
	lcd_pkg::rgb_t gray;
	lcd_pkg::rgb_t background;
	lcd_pkg::rgb_t pixel;

	// colour of bar number band, black past the last bar
	function automatic lcd_pkg::rgb_t band_rgb(input lcd_pkg::coord_t band);
		case (band)
			12'd0: band_rgb = `LCD_RED;
			12'd1: band_rgb = `LCD_GREEN;
			12'd2: band_rgb = `LCD_BLUE;
			12'd3: band_rgb = `LCD_WHITE;
			12'd4: band_rgb = `LCD_BLACK;
			12'd5: band_rgb = `LCD_YELLOW;
			12'd6: band_rgb = `LCD_CYAN;
			12'd7: band_rgb = `LCD_ROYAL;
			default: band_rgb = `LCD_BLACK;
		endcase
	endfunction

	// ------------------------------------------------------------------------
	// background patterns
	// ------------------------------------------------------------------------
	assign band_y = pos_y / BAND_H;
	assign band_x = pos_x / BAND_W;

	// 12 x 12 bits fills the colour exactly
	assign product = pos_x * pos_y;

	// gray ramp by line in the top half, by column below
	assign gray = (pos_y < HALF_V) ? {3{pos_y[7:0]}} : {3{pos_x[7:0]}};

	always_comb
	begin
		case (pattern)
			lcd_pkg::pat_hbars: background = band_rgb(band_y);
			lcd_pkg::pat_vbars: background = band_rgb(band_x);
			lcd_pkg::pat_product: background = product;
			lcd_pkg::pat_gray: background = gray;
			default: background = `LCD_BLACK;
		endcase
	end

	// ------------------------------------------------------------------------
	// overlay of the drawing records
	// ------------------------------------------------------------------------
	always_comb
	begin
		pixel = background;
		// later slots override earlier ones
		for (int i = 0; i < `LCD_SLOTS; i++)
		begin
			if (slot_valid[i]
				&& (pos_x >= slot_x0[i]) && (pos_x <= slot_x1[i])
				&& (pos_y >= slot_y0[i]) && (pos_y <= slot_y1[i]))
				pixel = slot_color[i];
		end
	end

	// output register, blank outside the visible area
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			lcd_data <= '0;
		else
			lcd_data <= pos_active ? pixel : '0;
	end

endmodule

`default_nettype wire

//--- lcd_cmd_store.sv
`timescale 1ns/10ps
`default_nettype none

`include "lcd_settings.svh"

module lcd_cmd_store
(
	input wire clk,
	input wire rst_n,
	input wire cmd_strobe,
	input wire lcd_pkg::cmd_word_t cmd_data,
	output logic [`LCD_SLOTS-1:0] slot_valid,
	output lcd_pkg::coord_t [`LCD_SLOTS-1:0] slot_x0,
	output lcd_pkg::coord_t [`LCD_SLOTS-1:0] slot_y0,
	output lcd_pkg::coord_t [`LCD_SLOTS-1:0] slot_x1,
	output lcd_pkg::coord_t [`LCD_SLOTS-1:0] slot_y1,
	output lcd_pkg::rgb_t [`LCD_SLOTS-1:0] slot_color,
	output lcd_pkg::pattern_t pattern
);

	localparam int PTR_W = (`LCD_SLOTS > 1) ? $clog2(`LCD_SLOTS) : 1;

	// header marker and opcodes
	localparam logic [7:0] CMD_MARK = 8'hFF;
	localparam logic [7:0] OP_PIXEL = 8'h00;
	localparam logic [7:0] OP_RECT = 8'h02;
	localparam logic [7:0] OP_PATTERN = 8'h03;
	localparam logic [7:0] OP_CLEAR = 8'h04;

	lcd_pkg::parse_state_t state;
	logic is_rect;
	logic [PTR_W-1:0] wr_ptr;

	// captured corners, unordered
	lcd_pkg::coord_t ax;
	lcd_pkg::coord_t ay;
	lcd_pkg::coord_t bx;
	lcd_pkg::coord_t by;

	// field views of the incoming word
	wire is_header = (cmd_data[31:24] == CMD_MARK);
	wire [7:0] opcode = cmd_data[15:8];
	wire lcd_pkg::coord_t word_x = cmd_data[27:16];
	wire lcd_pkg::coord_t word_y = cmd_data[11:0];

	wire rec_write = cmd_strobe && (state == lcd_pkg::st_color);
	wire [PTR_W-1:0] ptr_next = (wr_ptr == PTR_W'(`LCD_SLOTS - 1)) ? '0 : wr_ptr + 1'b1;

	// corners sorted so that x0 <= x1 and y0 <= y1
	wire lcd_pkg::coord_t lo_x = (ax <= bx) ? ax : bx;
	wire lcd_pkg::coord_t hi_x = (ax <= bx) ? bx : ax;
	wire lcd_pkg::coord_t lo_y = (ay <= by) ? ay : by;
	wire lcd_pkg::coord_t hi_y = (ay <= by) ? by : ay;

	// ------------------------------------------------------------------------
	// parser FSM, valid bits, pointer and pattern select
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= lcd_pkg::st_header;
			is_rect <= 1'b0;
			wr_ptr <= '0;
			slot_valid <= '0;
			pattern <= lcd_pkg::pat_hbars;
		end
		else if (cmd_strobe)
		begin
			case (state)
				lcd_pkg::st_header:
				begin
					// anything without the marker is dropped
					if (is_header)
					begin
						case (opcode)
							OP_PIXEL:
							begin
								is_rect <= 1'b0;
								state <= lcd_pkg::st_corner0;
							end
							OP_RECT:
							begin
								is_rect <= 1'b1;
								state <= lcd_pkg::st_corner0;
							end
							OP_PATTERN:
								pattern <= lcd_pkg::pattern_t'(cmd_data[1:0]);
							OP_CLEAR:
							begin
								slot_valid <= '0;
								wr_ptr <= '0;
							end
							default:
								state <= lcd_pkg::st_header;
						endcase
					end
				end
				lcd_pkg::st_corner0:
					state <= is_rect ? lcd_pkg::st_corner1 : lcd_pkg::st_color;
				lcd_pkg::st_corner1:
					state <= lcd_pkg::st_color;
				lcd_pkg::st_color:
				begin
					slot_valid[wr_ptr] <= 1'b1;
					wr_ptr <= ptr_next;
					state <= lcd_pkg::st_header;
				end
				default:
					state <= lcd_pkg::st_header;
			endcase
		end
	end

	// corner capture; a pixel gets both corners from its one word
	always_ff @(posedge clk)
	begin
		if (cmd_strobe && (state == lcd_pkg::st_corner0))
		begin
			ax <= word_x;
			ay <= word_y;
			bx <= word_x;
			by <= word_y;
		end
		else if (cmd_strobe && (state == lcd_pkg::st_corner1))
		begin
			bx <= word_x;
			by <= word_y;
		end
	end

	// ------------------------------------------------------------------------
	// record payload
	// ------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (rec_write)
		begin
			slot_x0[wr_ptr] <= lo_x;
			slot_y0[wr_ptr] <= lo_y;
			slot_x1[wr_ptr] <= hi_x;
			slot_y1[wr_ptr] <= hi_y;
			slot_color[wr_ptr] <= cmd_data[23:0];
		end
	end

endmodule

`default_nettype wire

//--- lcd_timing.sv
`timescale 1ns/10ps
`default_nettype none

`include "lcd_settings.svh"

module lcd_timing
(
	input wire clk,
	input wire rst_n,
	output lcd_pkg::coord_t pos_x,
	output lcd_pkg::coord_t pos_y,
	output logic pos_active,
	output logic lcd_de,
	output logic lcd_hsync,
	output logic lcd_vsync
);

	// line layout: visible, front porch, sync, back porch
	localparam lcd_pkg::coord_t H_LAST = lcd_pkg::coord_t'(`LCD_H_TOTAL - 1);
	localparam lcd_pkg::coord_t V_LAST = lcd_pkg::coord_t'(`LCD_V_TOTAL - 1);
	localparam lcd_pkg::coord_t H_SYNC_ON = lcd_pkg::coord_t'(`LCD_H_DISP + `LCD_H_FRONT);
	localparam lcd_pkg::coord_t H_SYNC_OFF = lcd_pkg::coord_t'(`LCD_H_DISP + `LCD_H_FRONT
		+ `LCD_H_SYNC);
	localparam lcd_pkg::coord_t V_SYNC_ON = lcd_pkg::coord_t'(`LCD_V_DISP + `LCD_V_FRONT);
	localparam lcd_pkg::coord_t V_SYNC_OFF = lcd_pkg::coord_t'(`LCD_V_DISP + `LCD_V_FRONT
		+ `LCD_V_SYNC);

	lcd_pkg::coord_t h_cnt;
	lcd_pkg::coord_t v_cnt;
	logic hsync_q;
	logic vsync_q;

	// ------------------------------------------------------------------------
	// scan counters
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			h_cnt <= '0;
			v_cnt <= '0;
		end
		else if (h_cnt == H_LAST)
		begin
			h_cnt <= '0;
			v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
		end
		else
			h_cnt <= h_cnt + 1'b1;
	end

	// ------------------------------------------------------------------------
	// position stage, first cycle of latency
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pos_x <= '0;
			pos_y <= '0;
			pos_active <= 1'b0;
			hsync_q <= 1'b1;
			vsync_q <= 1'b1;
		end
		else
		begin
			pos_x <= h_cnt;
			pos_y <= v_cnt;
			pos_active <= (h_cnt < lcd_pkg::coord_t'(`LCD_H_DISP))
				&& (v_cnt < lcd_pkg::coord_t'(`LCD_V_DISP));
			// syncs are active low
			hsync_q <= !((h_cnt >= H_SYNC_ON) && (h_cnt < H_SYNC_OFF));
			vsync_q <= !((v_cnt >= V_SYNC_ON) && (v_cnt < V_SYNC_OFF));
		end
	end

	// one more stage so enable and syncs line up with the colour register
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			lcd_de <= 1'b0;
			lcd_hsync <= 1'b1;
			lcd_vsync <= 1'b1;
		end
		else
		begin
			lcd_de <= pos_active;
			lcd_hsync <= hsync_q;
			lcd_vsync <= vsync_q;
		end
	end

endmodule

`default_nettype wire

//--- lcd_pkg.sv
`default_nettype none

package lcd_pkg;

	// pixel coordinate, wide enough for large panels
	typedef logic [11:0] coord_t;

	// colour, red in [23:16], green in [15:8], blue in [7:0]
	typedef logic [23:0] rgb_t;

	// raw word on the command input
	typedef logic [31:0] cmd_word_t;

	// background test patterns, encoded as in bits 1:0 of the pattern command
	typedef enum logic [1:0] {
		pat_hbars   = 2'd0,
		pat_vbars   = 2'd1,
		pat_product = 2'd2,
		pat_gray    = 2'd3
	} pattern_t;

	// command parser states
	typedef enum logic [1:0] {
		st_header  = 2'd0,
		st_corner0 = 2'd1,
		st_corner1 = 2'd2,
		st_color   = 2'd3
	} parse_state_t;

endpackage

`default_nettype wire

//--- lcd_settings.svh
`ifndef LCD_SETTINGS_SVH
`define LCD_SETTINGS_SVH

// ---------------------------------------------------------------------------
// panel timing, in pixels per line and lines per frame
// kept tiny so a frame simulates quickly
// ---------------------------------------------------------------------------
`define LCD_H_DISP   64
`define LCD_H_FRONT  4
`define LCD_H_SYNC   4
`define LCD_H_BACK   8

`define LCD_V_DISP   32
`define LCD_V_FRONT  2
`define LCD_V_SYNC   2
`define LCD_V_BACK   2

// full scan lengths
`define LCD_H_TOTAL  (`LCD_H_DISP + `LCD_H_FRONT + `LCD_H_SYNC + `LCD_H_BACK)
`define LCD_V_TOTAL  (`LCD_V_DISP + `LCD_V_FRONT + `LCD_V_SYNC + `LCD_V_BACK)

// ---------------------------------------------------------------------------
// drawing records held by the command store
// ---------------------------------------------------------------------------
`define LCD_SLOTS    4

// ---------------------------------------------------------------------------
// named colours, 24-bit rgb with red in the top byte
// ---------------------------------------------------------------------------
`define LCD_RED      24'hFF0000
`define LCD_GREEN    24'h00FF00
`define LCD_BLUE     24'h0000FF
`define LCD_WHITE    24'hFFFFFF
`define LCD_BLACK    24'h000000
`define LCD_YELLOW   24'hFFFF00
`define LCD_CYAN     24'h00FFFF
`define LCD_ROYAL    24'h4169E1

`endif
